/* Makefile */
TOP = x25519_addsub_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dv/x25519_addsub_tb.sv */
module x25519_addsub_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import x25519_pkg::*;

	localparam int ack_timeout = 40; // Cycles allowed for any single wait
	localparam logic [263:0] prime = (264'd1 << 255) - 264'd19; // 2^255 - 19

	logic clk;
	logic reset;
	logic req;
	logic op;
	field_word_t a;
	field_word_t b;
	logic ack;
	field_word_t result;

	integer seed;
	logic [263:0] exp_result; // Exact rule value of the operation in flight
	logic [263:0] exp_mod; // (a op b) mod p for chained operands
	logic chain_mode; // Current operation reuses an earlier result
	logic [263:0] last_result; // Result captured while ack was high

	x25519_addsub_unit i_dut (
		.clk(clk),
		.reset(reset),
		.req(req),
		.op(op),
		.a(a),
		.b(b),
		.ack(ack),
		.result(result)
	);

	always #2 clk = ~clk; // 4 ns period

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	// Bits 254..0 plus 19 times bits 263..255
	function automatic logic [263:0] fold_rule(input logic [263:0] raw);
		logic [263:0] low_part;
		logic [263:0] top_part;
		low_part = {9'd0, raw[254:0]};
		top_part = {255'd0, raw[263:255]};
		return low_part + top_part * 264'd19;
	endfunction

	// Raw add or offset subtract that both wrap at 2^264
	function automatic logic [263:0] expected_value(input logic opc, input logic [263:0] x,
		input logic [263:0] y);
		logic [263:0] raw;
		if (opc == op_add) begin
			raw = x + y;
		end else begin
			raw = x - y + prime; // Offset by p keeps it nonnegative
		end
		return fold_rule(raw);
	endfunction

	// Field value of x op y with both operands reduced first
	function automatic logic [263:0] field_mod(input logic opc, input logic [263:0] x,
		input logic [263:0] y);
		logic [263:0] xr;
		logic [263:0] yr;
		xr = x % prime;
		yr = y % prime;
		if (opc == op_add) begin
			return (xr + yr) % prime; // Sum stays below 2p
		end else begin
			return (xr + prime - yr) % prime;
		end
	endfunction

	// Eight 32-bit pieces with the top bits cleared below 2^255
	function automatic logic [263:0] random_operand();
		logic [263:0] v;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			v[i*32 +: 32] = $random(seed);
		end
		v[263:255] = '0;
		return v;
	endfunction

	// Polls one cycle at a time and gives up after ack_timeout cycles
	task automatic wait_for_ack(input logic level);
		int cycles;
		cycles = 0;
		while (ack !== level) begin
			if (cycles >= ack_timeout) begin
				report_failure($sformatf(
					"Timeout at %0t: ack did not go to %0b within %0d cycles",
					$time, level, ack_timeout));
			end else begin
				@(posedge clk);
				#1; // Look just after the edge
				cycles++;
			end
		end
	endtask

	// One full four-phase exchange started 1 ns after an edge with ack low
	task automatic run_op(input logic opc, input logic [263:0] x, input logic [263:0] y,
		input logic chained);
		int hold;
		op = opc;
		a.flat = x;
		b.flat = y;
		exp_result = expected_value(opc, x, y);
		exp_mod = field_mod(opc, x, y);
		chain_mode = chained;
		req = 1'b1;
		wait_for_ack(1'b1);
		last_result = result.flat;
		hold = $unsigned($random(seed)) % 9; // Extra cycles with req still high
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		req = 1'b0;
		wait_for_ack(1'b0); // Unit ready for the next request
	endtask

	// Ack low coming out of reset
	reset_ack_low: assert property (@(posedge clk) $fell(reset) |-> !ack)
		else report_failure("ack was high on the first cycle after reset");

	// Request sampled at E0 and ack sampled high at E5
	ack_latency: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> ($past(req, 5) && !$past(req, 6)))
		else report_failure("ack rose at the wrong distance from the request");

	ack_has_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req))
		else report_failure("ack rose while req was low");

	ack_holds: assert property (@(posedge clk) disable iff (reset)
		(ack && req) |=> ack)
		else report_failure("ack dropped while req was still high");

	// Falls one edge after req is first seen low
	ack_release: assert property (@(posedge clk) disable iff (reset)
		$fell(ack) |-> (!$past(req) && !$past(req, 2) && $past(req, 3)))
		else report_failure("ack fell at the wrong distance from the req release");

	result_value: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> (result.flat == exp_result))
		else report_failure($sformatf("FAILED time=%0t signal=result expected=%h actual=%h",
			$time, exp_result, result.flat));

	result_top_clear: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> (result.flat[263:256] == 8'd0))
		else report_failure($sformatf(
			"FAILED time=%0t signal=result[263:256] expected=%h actual=%h",
			$time, 8'd0, result.flat[263:256]));

	// Only meaningful once operands are unreduced
	result_mod: assert property (@(posedge clk) disable iff (reset)
		($rose(ack) && chain_mode) |-> ((result.flat % prime) == exp_mod))
		else report_failure($sformatf(
			"FAILED time=%0t signal=result_mod_p expected=%h actual=%h",
			$time, exp_mod, result.flat % prime));

	result_stable: assert property (@(posedge clk) disable iff (reset)
		(ack && $past(ack)) |-> $stable(result.flat))
		else report_failure("result changed while ack was high");

	no_launch_while_ack: assert property (@(posedge clk) disable iff (reset)
		ack |-> !(i_dut.add_en || i_dut.sub_en))
		else report_failure("a pipeline was launched while ack was high");

	initial begin
		logic [263:0] x;
		logic [263:0] y;
		logic [263:0] t;
		logic opc;
		seed = 32'hc729_013c;
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		op = op_add;
		a = '0;
		b = '0;
		exp_result = '0;
		exp_mod = '0;
		chain_mode = 1'b0;
		last_result = '0;

		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;

		// Addition edge cases come first
		run_op(op_add, 264'd0, 264'd0, 1'b0);
		run_op(op_add, prime - 264'd1, prime - 264'd1, 1'b0); // Sum crosses 2^255
		for (int i = 0; i < 8; i++) begin
			x = random_operand();
			y = random_operand();
			run_op(op_add, x, y, 1'b0);
		end

		// Subtraction with a >= b
		for (int i = 0; i < 6; i++) begin
			x = random_operand();
			y = random_operand();
			if (x < y) begin
				t = x;
				x = y;
				y = t;
			end
			run_op(op_sub, x, y, 1'b0);
		end
		x = random_operand();
		run_op(op_sub, x, x, 1'b0); // Lands exactly on p

		// Subtraction with a < b
		for (int i = 0; i < 6; i++) begin
			x = random_operand();
			y = random_operand();
			if (x > y) begin
				t = x;
				x = y;
				y = t;
			end
			run_op(op_sub, x, y, 1'b0);
		end
		run_op(op_sub, 264'd0, prime - 264'd1, 1'b0);

		// Low half borrow into the high half
		for (int i = 0; i < 4; i++) begin
			x = random_operand();
			y = random_operand();
			x[127:0] = '0;
			y[127:0] = '1;
			run_op(op_sub, x, y, 1'b0);
		end

		// Chaining starts from p itself
		x = random_operand();
		run_op(op_sub, x, x, 1'b0);
		for (int i = 0; i < 8; i++) begin
			opc = 1'($random(seed));
			if (i % 3 == 2) begin
				y = last_result; // Both operands unreduced
			end else begin
				y = random_operand();
			end
			run_op(opc, last_result, y, 1'b1);
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* files.f */
logic/x25519_pkg.sv
logic/x25519_sub.sv
logic/x25519_add.sv
logic/x25519_fold.sv
logic/x25519_addsub_unit.sv
dv/x25519_addsub_tb.sv

/* logic/x25519_add.sv */
module x25519_add (
	input logic clk,
	input logic reset,
	input logic en,
	input x25519_pkg::field_word_t a,
	input x25519_pkg::field_word_t b,
	output logic out_valid,
	output x25519_pkg::field_word_t out
);
	import x25519_pkg::*;

	logic en_q; // Stage one holds valid data
	logic [low_width:0] sum_low; // Low half with its carry out
	logic [high_width-1:0] sum_high; // High half before carry

	always_ff @(posedge clk) begin
		if (reset) begin
			en_q <= 1'b0;
			out_valid <= 1'b0;
			sum_low <= '0;
			sum_high <= '0;
			out <= '0;
		end else begin
			en_q <= en;
			out_valid <= en_q;

			// Halves added independently in stage one
			if (en) begin
				sum_low <= {1'b0, a.halves.low} + {1'b0, b.halves.low};
				sum_high <= a.halves.high + b.halves.high; // Top carry dropped
			end

			// Low carry rippled up here
			if (en_q) begin
				out.halves.high <= sum_high + high_width'(sum_low[low_width]);
				out.halves.low <= sum_low[low_width-1:0];
			end
		end
	end

	add_valid_latency: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(en, 2));

endmodule

/* logic/x25519_addsub_unit.sv */
module x25519_addsub_unit (
	input logic clk,
	input logic reset,
	input logic req,
	input logic op,
	input x25519_pkg::field_word_t a,
	input x25519_pkg::field_word_t b,
	output logic ack,
	output x25519_pkg::field_word_t result
);
	import x25519_pkg::*;

	logic [1:0] state; // Control FSM
	logic launch; // New request accepted this cycle

	field_word_t a_q; // Captured operands
	field_word_t b_q;
	logic op_q; // Captured opcode, steers the fold input

	logic add_en; // One cycle launch pulses
	logic sub_en;

	logic add_valid;
	field_word_t add_out;
	logic sub_valid;
	field_word_t sub_out;

	logic fold_in_valid;
	field_word_t fold_value;
	logic fold_valid;
	field_word_t fold_out;

	// Ack must be low before a fresh request counts
	assign launch = (state == state_idle) && req && !ack;

	x25519_add i_add (
		.clk(clk),
		.reset(reset),
		.en(add_en),
		.a(a_q),
		.b(b_q),
		.out_valid(add_valid),
		.out(add_out)
	);

	x25519_sub i_sub (
		.clk(clk),
		.reset(reset),
		.en(sub_en),
		.a(a_q),
		.b(b_q),
		.out_valid(sub_valid),
		.out(sub_out)
	);

	// Only the launched pipeline ever fires
	assign fold_in_valid = add_valid | sub_valid;
	assign fold_value = (op_q == op_sub) ? sub_out : add_out;

	x25519_fold i_fold (
		.clk(clk),
		.reset(reset),
		.in_valid(fold_in_valid),
		.value(fold_value),
		.out_valid(fold_valid),
		.out(fold_out)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= state_idle;
			a_q <= '0;
			b_q <= '0;
			op_q <= op_add;
			add_en <= 1'b0;
			sub_en <= 1'b0;
			ack <= 1'b0;
			result <= '0;
		end else begin
			add_en <= launch && (op == op_add); // Pulse lines up with the operands
			sub_en <= launch && (op == op_sub);

			if (launch) begin
				a_q <= a;
				b_q <= b;
				op_q <= op;
			end

			case (state)
				state_idle: begin
					ack <= 1'b0; // Drops one edge after req seen low
					if (launch) begin
						state <= state_busy;
					end
				end
				state_busy: begin
					if (fold_valid) begin
						result <= fold_out; // Held until the next launch completes
						ack <= 1'b1;
						state <= state_done;
					end
				end
				state_done: begin
					if (!req) begin // Requester has seen ack
						state <= state_idle;
					end
				end
				default: begin
					state <= state_idle;
				end
			endcase
		end
	end

	// Ack only answers a request that was up when it rose
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req));

	// Launch pulses are only issued from idle
	en_from_idle: assert property (@(posedge clk) disable iff (reset)
		(add_en || sub_en) |-> ($past(state) == state_idle));

	en_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(add_en && sub_en));

endmodule

/* logic/x25519_fold.sv */
module x25519_fold (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input x25519_pkg::field_word_t value,
	output logic out_valid,
	output x25519_pkg::field_word_t out
);
	import x25519_pkg::*;

	logic [field_width-fold_bit-1:0] high_part; // Bits 263..255, worth 2^255 each
	logic [field_width-fold_bit+4:0] fold_term; // high_part * 19, at most 9709
	logic [field_width-1:0] fold_sum; // Below 2^255 + 2^14

	// 2^255 == 19 (mod p) so the top bits come back in scaled by 19
	always_comb begin
		high_part = value.flat[field_width-1:fold_bit];
		fold_term = high_part * fold_mult;
		fold_sum = field_width'(value.flat[fold_bit-1:0]) + field_width'(fold_term);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out <= '0;
		end else begin
			out_valid <= in_valid; // One cycle latency
			if (in_valid) begin
				out.flat <= fold_sum;
			end
		end
	end

	// Folded word fits below 2^256
	fold_top_clear: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (out.flat[field_width-1:fold_bit+1] == '0));

endmodule

/* logic/x25519_pkg.sv */
package x25519_pkg;

	localparam int field_width = 264; // Unreduced word, 9 spare bits above 2^255
	localparam int low_width = 128; // Lower split
	localparam int high_width = 136; // Upper split

	// p = 2^255 - 19, cut at bit 128
	localparam logic [low_width-1:0] p_low =
		128'hffff_ffff_ffff_ffff_ffff_ffff_ffff_ffed;
	localparam logic [high_width-1:0] p_high =
		136'h00_7fff_ffff_ffff_ffff_ffff_ffff_ffff_ffff;

	localparam int fold_bit = 255; // First bit folded back in
	localparam logic [4:0] fold_mult = 5'd19; // 2^255 mod p

	localparam logic op_add = 1'b0;
	localparam logic op_sub = 1'b1;

	// Top level control states
	localparam logic [1:0] state_idle = 2'd0;
	localparam logic [1:0] state_busy = 2'd1; // Operation in a pipeline or the fold
	localparam logic [1:0] state_done = 2'd2; // Result held, ack up

	typedef struct packed {
		logic [high_width-1:0] high; // Bits 263..128
		logic [low_width-1:0] low; // Bits 127..0
	} field_halves_t;

	// Same word seen flat or as two halves
	typedef union packed {
		logic [field_width-1:0] flat;
		field_halves_t halves;
	} field_word_t;

endpackage

/* logic/x25519_sub.sv */
module x25519_sub (
	input logic clk,
	input logic reset,
	input logic en,
	input x25519_pkg::field_word_t a,
	input x25519_pkg::field_word_t b,
	output logic out_valid,
	output x25519_pkg::field_word_t out
);
	import x25519_pkg::*;

	logic en_q; // Stage one holds valid data
	logic [low_width+1:0] sum_low; // Low half plus two carry bits
	logic [high_width-1:0] sum_high; // High half biased by -1
	logic [low_width+1:0] low_next;
	logic [high_width-1:0] high_next;

	// Adding p keeps the total positive.
	// ~b + 1 stands in for 2^128 - b so the low sum never underflows;
	// its carry lands in 0..2 and the high half takes the matching -1
	always_comb begin
		low_next = {2'b00, a.halves.low} + {2'b00, ~b.halves.low} + {2'b00, p_low}
			+ (low_width + 2)'(1);
		high_next = a.halves.high + ~b.halves.high + p_high; // a - b - 1 + p_high
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			en_q <= 1'b0;
			out_valid <= 1'b0;
			sum_low <= '0;
			sum_high <= '0;
			out <= '0;
		end else begin
			en_q <= en;
			out_valid <= en_q;
			if (en) begin
				sum_low <= low_next;
				sum_high <= high_next;
			end
			if (en_q) begin
				out.halves.high <= sum_high
					+ high_width'(sum_low[low_width+1:low_width]); // Wraps mod 2^264
				out.halves.low <= sum_low[low_width-1:0];
			end
		end
	end

	sub_valid_latency: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(en, 2));

endmodule
